/* verilog.f */
src/fifo_cfg_pkg.sv
src/fifo_types_pkg.sv
src/fifo_ram.sv
src/std_fifo.sv
src/fwft_fifo.sv
src/sample_fifo_top.sv
sim/sample_fifo_asserts.sv
sim/sample_fifo_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the sample buffer testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wall -Wno-fatal \
  --top-module sample_fifo_tb -f verilog.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Errors found" "$LOG"; then
  echo "Simulation FAILED"
  exit 1
fi
if [ $status -ne 0 ] || ! grep -q "No errors" "$LOG"; then
  echo "Simulation did not finish cleanly"
  exit 1
fi

echo "Simulation PASSED"
exit 0

/* sim/sample_fifo_tb.sv */
`timescale 1ns/1ps
/* sample_fifo_tb: clock, reset, stimulus phases and reference queue
   for the sample buffer, with a bounded wait for every condition */
module sample_fifo_tb;

  logic                         RD_CLK = 1'b0;
  logic                         RESET  = 1'b1;
  fifo_types_pkg::fifo_wr_t     wr     = '0;
  logic                         rden   = 1'b0;
  fifo_types_pkg::sample_t      dout;
  logic                         empty;
  logic                         almost_empty;
  fifo_types_pkg::fifo_status_t status;

  int                      seed = 32'hc587;
  fifo_types_pkg::sample_t ref_q[$];  // words accepted but not yet consumed
  int                      accepted;
  int                      consumed;
  string                   test_name = "reset";
  bit                      high_seen;
  bit                      af_seen;
  bit                      full_early;  // full showed up before almost_full

  localparam int TOTAL_WORDS = fifo_cfg_pkg::DEPTH + fifo_cfg_pkg::PREFETCH_WORDS;

  sample_fifo_top uut (
    .RD_CLK       (RD_CLK),
    .RESET        (RESET),
    .wr           (wr),
    .rden         (rden),
    .dout         (dout),
    .empty        (empty),
    .almost_empty (almost_empty),
    .status       (status)
  );

  always #20 RD_CLK = ~RD_CLK;

  task automatic abort_run(input string reason);
    $display("%s in test %s", reason, test_name);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic report_mismatch(input int expected, input int actual);
    $display("[FAIL] %s: expected %0h, actual %0h", test_name, expected, actual);
    $display("Errors found");
    $fatal(1);
  endtask

  // reference model follows the values present before each edge
  always @(posedge RD_CLK) begin
    if (!RESET) begin
      if (rden && !empty) begin
        if (ref_q.size() == 0) begin
          abort_run("a word was read that was never written");
        end else if (dout !== ref_q[0]) begin
          report_mismatch(ref_q[0], dout);
        end else begin
          void'(ref_q.pop_front());
          consumed++;
        end
      end
      if (wr.wren && !status.full) begin
        ref_q.push_back(wr.data);
        accepted++;
      end
      if (status.high) high_seen = 1'b1;
      if (status.full && !af_seen) full_early = 1'b1;
      if (status.almost_full) af_seen = 1'b1;
    end
  end

  task automatic wait_not_empty(input int limit);
    int n;
    n = 0;
    while (empty) begin
      if (n == limit) abort_run("timeout while waiting for empty to fall");
      @(posedge RD_CLK);
      n++;
    end
  endtask

  // rden is expected high while this runs
  task automatic drain_all(input int limit);
    int n;
    n = 0;
    while (ref_q.size() != 0 || !empty) begin
      if (n == limit) abort_run("timeout while draining the buffer");
      @(posedge RD_CLK);
      n++;
    end
  endtask

  task automatic fill_until_full(input int limit);
    int  n;
    bit  done;
    n    = 0;
    done = 1'b0;
    @(posedge RD_CLK);
    wr <= '{wren: 1'b1, data: $random(seed)};
    while (!done) begin
      @(posedge RD_CLK);
      if (status.almost_full && wr.wren) begin
        wr.wren <= 1'b0;  // this edge takes the last core slot
        done = 1'b1;
      end else begin
        wr <= '{wren: 1'b1, data: $random(seed)};
      end
      n++;
      if (!done && n == limit) abort_run("timeout while filling the buffer");
    end
  endtask

  initial begin
    repeat (10) @(posedge RD_CLK);
    RESET <= 1'b0;
    repeat (2) @(posedge RD_CLK);

    test_name = "fall_through";
    wr <= '{wren: 1'b1, data: $random(seed)};
    @(posedge RD_CLK);
    wr.wren <= 1'b0;
    wait_not_empty(8);
    rden <= 1'b1;
    @(posedge RD_CLK);
    rden <= 1'b0;
    repeat (2) @(posedge RD_CLK);

    test_name = "streaming";
    repeat (200) begin
      @(posedge RD_CLK);
      wr   <= '{wren: 1'($random(seed)), data: $random(seed)};
      rden <= 1'($random(seed));
    end
    @(posedge RD_CLK);
    wr.wren <= 1'b0;
    rden    <= 1'b1;
    drain_all(80);
    rden <= 1'b0;

    test_name  = "fill_levels";
    accepted   = 0;
    high_seen  = 1'b0;
    af_seen    = 1'b0;
    full_early = 1'b0;
    fill_until_full(40);
    repeat (3) @(posedge RD_CLK);
    if (!status.full) abort_run("full did not hold after filling");
    if (accepted != TOTAL_WORDS) report_mismatch(TOTAL_WORDS, accepted);
    if (!high_seen) abort_run("high was never raised while filling");
    if (full_early) abort_run("full rose before almost_full");

    test_name = "overflow";
    wr <= '{wren: 1'b1, data: $random(seed)};
    @(posedge RD_CLK);
    wr.wren <= 1'b0;
    repeat (3) @(posedge RD_CLK);
    if (accepted != TOTAL_WORDS) report_mismatch(TOTAL_WORDS, accepted);
    consumed = 0;
    rden <= 1'b1;
    drain_all(80);
    rden <= 1'b0;
    if (consumed != TOTAL_WORDS) report_mismatch(TOTAL_WORDS, consumed);
    repeat (2) @(posedge RD_CLK);

    $display("No errors");
    $finish;
  end

endmodule

/* sim/sample_fifo_asserts.sv */
`timescale 1ns/1ps
/* sample_fifo_asserts: concurrent checks on the sample buffer top level,
   bound into sample_fifo_top */
module sample_fifo_asserts (
  input logic                         RD_CLK,
  input logic                         RESET,
  input fifo_types_pkg::fifo_wr_t     wr,
  input logic                         rden,
  input fifo_types_pkg::sample_t      dout,
  input logic                         empty,
  input logic                         almost_empty,
  input fifo_types_pkg::fifo_status_t status,
  input logic                         core_rden,
  input logic                         core_empty
);

  int core_words;  // words held by the core, from accepted writes and issued reads

  always_ff @(posedge RD_CLK) begin
    if (RESET) begin
      core_words <= 0;
    end else begin
      core_words <= core_words + int'(wr.wren && !status.full) - int'(core_rden);
    end
  end

  // all outputs sit at their idle values once reset is released
  a_reset_state: assert property (@(posedge RD_CLK)
    $fell(RESET) |-> empty && !almost_empty && status == '0 && dout == '0)
    else $error("outputs not idle after reset");

  // a write into a fully idle buffer shows up two cycles after its edge
  a_fall_through: assert property (@(posedge RD_CLK) disable iff (RESET)
    (empty && core_empty && !$past(core_rden) && wr.wren)
    |=> empty ##1 empty ##1 (!empty && dout == $past(wr.data, 3)
        && (almost_empty || $past(wr.wren) || $past(wr.wren, 2))))
    else $error("first word did not fall through on time");

  // an unconsumed head word stays in place
  a_head_holds: assert property (@(posedge RD_CLK) disable iff (RESET)
    (!empty && !rden) |=> (!empty && $stable(dout)))
    else $error("head word changed without a read");

  a_no_core_underrun: assert property (@(posedge RD_CLK) disable iff (RESET)
    core_rden |-> core_words > 0)
    else $error("core read while the core is empty");

  a_full_af: assert property (@(posedge RD_CLK) disable iff (RESET)
    status.full |-> status.almost_full)
    else $error("full without almost_full");

  a_af_high: assert property (@(posedge RD_CLK) disable iff (RESET)
    status.almost_full |-> status.high)
    else $error("almost_full without high");

  a_overflow: assert property (@(posedge RD_CLK) disable iff (RESET)
    !$past(RESET) |-> status.overflow == $past(wr.wren && status.full))
    else $error("overflow does not match a refused write");

endmodule

bind sample_fifo_top sample_fifo_asserts checks (
  .RD_CLK       (RD_CLK),
  .RESET        (RESET),
  .wr           (wr),
  .rden         (rden),
  .dout         (dout),
  .empty        (empty),
  .almost_empty (almost_empty),
  .status       (status),
  .core_rden    (core_rden),
  .core_empty   (core_empty)
);

/* src/sample_fifo_top.sv */
`timescale 1ns/1ps
/* sample_fifo_top: sample buffer built from the std_fifo core
   and the fwft_fifo prefetch stage */
module sample_fifo_top (
  input  logic                         RD_CLK,
  input  logic                         RESET,
  input  fifo_types_pkg::fifo_wr_t     wr,
  input  logic                         rden,
  output fifo_types_pkg::sample_t      dout,
  output logic                         empty,
  output logic                         almost_empty,
  output fifo_types_pkg::fifo_status_t status
);

  fifo_types_pkg::sample_t core_dout;
  logic                    core_empty;
  logic                    core_rden;

  std_fifo core (
    .RD_CLK (RD_CLK),
    .RESET  (RESET),
    .wr     (wr),
    .rden   (core_rden),
    .dout   (core_dout),
    .empty  (core_empty),
    .status (status)
  );

  // hides the core read latency from the consumer
  fwft_fifo prefetch (
    .RD_CLK       (RD_CLK),
    .RESET        (RESET),
    .core_dout    (core_dout),
    .core_empty   (core_empty),
    .core_rden    (core_rden),
    .rden         (rden),
    .dout         (dout),
    .empty        (empty),
    .almost_empty (almost_empty)
  );

endmodule

/* src/fwft_fifo.sv */
`timescale 1ns/1ps
/* fwft_fifo: three-register prefetch that turns a one-cycle-latency core
   into a first-word-fall-through FIFO, with empty and almost_empty */
module fwft_fifo (
  input  logic                    RD_CLK,
  input  logic                    RESET,
  input  fifo_types_pkg::sample_t core_dout,
  input  logic                    core_empty,
  output logic                    core_rden,
  input  logic                    rden,
  output fifo_types_pkg::sample_t dout,
  output logic                    empty,
  output logic                    almost_empty
);

  fifo_types_pkg::sample_t mid_dout;
  logic                    ret_valid;  // core_dout carries a word not yet taken
  logic                    mid_valid;
  logic                    out_valid;
  logic                    upd_mid;
  logic                    upd_out;

  // the output register loads whenever it is free or being consumed
  assign upd_out = (mid_valid || ret_valid) && (rden || !out_valid);

  // park the returning word when the output cannot take it directly
  assign upd_mid = ret_valid && (mid_valid == upd_out);

  // stop reading once all three slots would be occupied
  assign core_rden = !core_empty && !(ret_valid && mid_valid && out_valid);

  assign empty        = !out_valid;
  assign almost_empty = out_valid && !mid_valid && !ret_valid && core_empty;

  always_ff @(posedge RD_CLK) begin
    if (upd_mid) begin
      mid_dout <= core_dout;
    end
  end

  always_ff @(posedge RD_CLK) begin
    if (RESET) begin
      dout <= '0;
    end else if (upd_out) begin
      dout <= mid_valid ? mid_dout : core_dout;  // middle word is older
    end
  end

  always_ff @(posedge RD_CLK) begin
    if (RESET) begin
      ret_valid <= 1'b0;
      mid_valid <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      // a new read replaces the returning word as it is taken
      if (core_rden) begin
        ret_valid <= 1'b1;
      end else if (upd_mid || upd_out) begin
        ret_valid <= 1'b0;
      end

      if (upd_mid) begin
        mid_valid <= 1'b1;
      end else if (upd_out) begin
        mid_valid <= 1'b0;
      end

      if (upd_out) begin
        out_valid <= 1'b1;
      end else if (rden) begin
        out_valid <= 1'b0;
      end
    end
  end

endmodule

/* src/std_fifo.sv */
`timescale 1ns/1ps
/* std_fifo: single clock FIFO core built on fifo_ram, with pointers,
   occupancy count, full, almost_full and high flags and the overflow pulse */
module std_fifo (
  input  logic                         RD_CLK,
  input  logic                         RESET,
  input  fifo_types_pkg::fifo_wr_t     wr,
  input  logic                         rden,
  output fifo_types_pkg::sample_t      dout,
  output logic                         empty,
  output fifo_types_pkg::fifo_status_t status
);

  fifo_types_pkg::fifo_addr_t  wptr;
  fifo_types_pkg::fifo_addr_t  rptr;
  fifo_types_pkg::fifo_count_t count;
  logic                        full;
  logic                        almost_full;
  logic                        high;
  logic                        overflow;
  logic                        wr_ok;
  logic                        rd_ok;

  // flags follow the count directly so they settle right after the edge
  assign full        = count == fifo_types_pkg::fifo_count_t'(fifo_cfg_pkg::DEPTH);
  assign almost_full = count >= fifo_types_pkg::fifo_count_t'(fifo_cfg_pkg::ALMOST_FULL_LEVEL);
  assign high        = count >= fifo_types_pkg::fifo_count_t'(fifo_cfg_pkg::PROG_FULL_LEVEL);
  assign empty       = count == '0;

  assign wr_ok = wr.wren && !full;  // writes while full are dropped
  assign rd_ok = rden && !empty;

  fifo_ram ram (
    .RD_CLK (RD_CLK),
    .we     (wr_ok),
    .waddr  (wptr),
    .wdata  (wr.data),
    .re     (rd_ok),
    .raddr  (rptr),
    .rdata  (dout)
  );

  always_ff @(posedge RD_CLK) begin
    if (RESET) begin
      wptr <= '0;
      rptr <= '0;
    end else begin
      if (wr_ok) begin
        wptr <= wptr + 1'b1;  // wraps at DEPTH
      end
      if (rd_ok) begin
        rptr <= rptr + 1'b1;
      end
    end
  end

  // simultaneous read and write leave the count unchanged
  always_ff @(posedge RD_CLK) begin
    if (RESET) begin
      count <= '0;
    end else begin
      case ({wr_ok, rd_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge RD_CLK) begin
    if (RESET) begin
      overflow <= 1'b0;
    end else begin
      overflow <= wr.wren && full;  // high for the one cycle after a refused write
    end
  end

  assign status = '{
    full:        full,
    almost_full: almost_full,
    high:        high,
    overflow:    overflow
  };

endmodule

/* src/fifo_ram.sv */
`timescale 1ns/1ps
/* fifo_ram: simple dual-port memory of DEPTH samples,
   synchronous write and registered read that holds when re is low */
module fifo_ram (
  input  logic                       RD_CLK,
  input  logic                       we,
  input  fifo_types_pkg::fifo_addr_t waddr,
  input  fifo_types_pkg::sample_t    wdata,
  input  logic                       re,
  input  fifo_types_pkg::fifo_addr_t raddr,
  output fifo_types_pkg::sample_t    rdata
);

  fifo_types_pkg::sample_t mem [fifo_cfg_pkg::DEPTH];

  always_ff @(posedge RD_CLK) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // block RAM output register, the word shows up one cycle after re
  always_ff @(posedge RD_CLK) begin
    if (re) begin
      rdata <= mem[raddr];
    end
  end

endmodule

/* src/fifo_types_pkg.sv */
/* fifo_types_pkg: sample, address and count types of the buffer,
   plus the write request and core status structs */
package fifo_types_pkg;

  typedef logic [fifo_cfg_pkg::SAMPLE_WIDTH-1:0] sample_t;
  typedef logic [fifo_cfg_pkg::ADDR_WIDTH-1:0]   fifo_addr_t;
  typedef logic [fifo_cfg_pkg::ADDR_WIDTH:0]     fifo_count_t;  // one extra bit so DEPTH fits

  // write request from the producer
  typedef struct packed {
    logic    wren;
    sample_t data;
  } fifo_wr_t;

  // fill-level flags of the core
  typedef struct packed {
    logic full;
    logic almost_full;
    logic high;
    logic overflow;  // a write was refused on the previous edge
  } fifo_status_t;

endpackage

/* src/fifo_cfg_pkg.sv */
/* fifo_cfg_pkg: fixed sizes and fill thresholds of the sample buffer,
   covering the core memory and the prefetch stage */
package fifo_cfg_pkg;

  // one sample as written by the producer
  localparam int SAMPLE_WIDTH = 32;

  // core memory geometry, the depth must stay a power of two
  localparam int ADDR_WIDTH = 4;
  localparam int DEPTH      = 2 ** ADDR_WIDTH;

  // core counts at which the status flags rise
  localparam int ALMOST_FULL_LEVEL = 15;
  localparam int PROG_FULL_LEVEL   = 12;

  // returning word, middle register and output register
  localparam int PREFETCH_WORDS = 3;

endpackage
